// ==== Makefile ====
TOP := tb_mips

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f \
		--Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	grep -q "^Test passed$$" run.log

clean:
	rm -rf obj_dir run.log

// ==== files.f ====
+incdir+.
mips_pkg.sv
mips_alu.sv
mips_grf.sv
mips_hazard.sv
mips_fetch.sv
mips_decode.sv
mips.sv
mips_assertions.sv
mips_checker.sv
tb_mips.sv

// ==== mips.sv ====
`default_nettype none

`include "mips_defines.svh"

module mips (
    input  logic                    clk,
    input  logic                    rst,

    output logic [31:0]             i_inst_addr,
    input  logic [31:0]             i_inst_rdata,

    input  logic [`MIPS_DATA_W-1:0] m_data_rdata,
    output logic [31:0]             m_data_addr,
    output logic [`MIPS_DATA_W-1:0] m_data_wdata,
    output logic                    m_data_we,

    output logic                    w_grf_we,
    output logic [`MIPS_REG_AW-1:0] w_grf_addr,
    output logic [`MIPS_DATA_W-1:0] w_grf_wdata,
    output logic [31:0]             w_inst_addr
);
    import mips_pkg::*;

    logic                    stall;
    logic                    branch_taken;
    logic [31:0]             branch_target;
    logic [31:0]             if_instr;
    logic [31:0]             if_pc;
    ctrl_t                   dec_ctrl;
    logic [`MIPS_REG_AW-1:0] dec_rs;
    logic [`MIPS_REG_AW-1:0] dec_rt;
    logic [`MIPS_DATA_W-1:0] dec_imm;
    logic                    dec_rs_use;
    logic                    dec_rt_use;
    logic [`MIPS_DATA_W-1:0] grf_rs;
    logic [`MIPS_DATA_W-1:0] grf_rt;
    logic [`MIPS_DATA_W-1:0] dec_rs_val;
    logic [`MIPS_DATA_W-1:0] dec_rt_val;
    logic [`MIPS_DATA_W-1:0] ex_rs_val;
    logic [`MIPS_DATA_W-1:0] ex_rt_val;
    logic [`MIPS_DATA_W-1:0] alu_y;
    fwd_sel_e                fwd_dec_rs;
    fwd_sel_e                fwd_dec_rt;
    fwd_sel_e                fwd_ex_rs;
    fwd_sel_e                fwd_ex_rt;
    id_ex_t                  id_ex;
    ex_mem_t                 ex_mem;
    mem_wb_t                 mem_wb;

    function automatic logic [`MIPS_DATA_W-1:0] fwd_pick(
        input fwd_sel_e                sel,
        input logic [`MIPS_DATA_W-1:0] reg_val,
        input logic [`MIPS_DATA_W-1:0] ex_mem_val,
        input logic [`MIPS_DATA_W-1:0] mem_wb_val
    );
        case (sel)
            FWD_EX_MEM: return ex_mem_val;
            FWD_MEM_WB: return mem_wb_val;
            default:    return reg_val;
        endcase
    endfunction

    mips_fetch u_fetch (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .pc(i_inst_addr)
    );

    // IF/ID holds while stalled, reset leaves a nop behind
    always_ff @(posedge clk) begin
        if (rst) begin
            if_instr <= '0;
        end else if (!stall) begin
            if_instr <= i_inst_rdata;
        end
        if (!stall) begin
            if_pc <= i_inst_addr;
        end
    end

    mips_decode u_decode (
        .instr(if_instr),
        .pc(if_pc),
        .rs_val(dec_rs_val),
        .rt_val(dec_rt_val),
        .ctrl(dec_ctrl),
        .rs_addr(dec_rs),
        .rt_addr(dec_rt),
        .imm(dec_imm),
        .rs_use(dec_rs_use),
        .rt_use(dec_rt_use),
        .branch_taken(branch_taken),
        .branch_target(branch_target)
    );

    mips_grf u_grf (
        .clk(clk),
        .rst(rst),
        .we(mem_wb.ctrl.reg_write),
        .waddr(mem_wb.ctrl.dst),
        .wdata(mem_wb.wdata),
        .raddr1(dec_rs),
        .raddr2(dec_rt),
        .rdata1(grf_rs),
        .rdata2(grf_rt)
    );

    mips_hazard u_hazard (
        .dec_rs(dec_rs),
        .dec_rt(dec_rt),
        .rs_use(dec_rs_use),
        .rt_use(dec_rt_use),
        .id_ex(id_ex),
        .ex_mem(ex_mem.ctrl),
        .mem_wb(mem_wb.ctrl),
        .stall(stall),
        .fwd_dec_rs(fwd_dec_rs),
        .fwd_dec_rt(fwd_dec_rt),
        .fwd_ex_rs(fwd_ex_rs),
        .fwd_ex_rt(fwd_ex_rt)
    );

    assign dec_rs_val = fwd_pick(fwd_dec_rs, grf_rs, ex_mem.alu, mem_wb.wdata);
    assign dec_rt_val = fwd_pick(fwd_dec_rt, grf_rt, ex_mem.alu, mem_wb.wdata);

    // a stall turns the ID/EX slot into a bubble
    always_ff @(posedge clk) begin
        id_ex <= '{ctrl: dec_ctrl, pc: if_pc, rs_addr: dec_rs, rt_addr: dec_rt,
                   rs_val: dec_rs_val, rt_val: dec_rt_val, imm: dec_imm};
        if (rst || stall) begin
            id_ex.ctrl <= '0;
        end
    end

    assign ex_rs_val = fwd_pick(fwd_ex_rs, id_ex.rs_val, ex_mem.alu, mem_wb.wdata);
    assign ex_rt_val = fwd_pick(fwd_ex_rt, id_ex.rt_val, ex_mem.alu, mem_wb.wdata);

    mips_alu u_alu (
        .op(id_ex.ctrl.alu_op),
        .a(ex_rs_val),
        .b(id_ex.ctrl.use_imm ? id_ex.imm : ex_rt_val),
        .y(alu_y)
    );

    always_ff @(posedge clk) begin
        ex_mem <= '{ctrl: id_ex.ctrl, pc: id_ex.pc, alu: alu_y, store_data: ex_rt_val};
        if (rst) begin
            ex_mem.ctrl <= '0;
        end
    end

    // data memory port, word stores only
    assign m_data_addr  = ex_mem.alu;
    assign m_data_wdata = ex_mem.store_data;
    assign m_data_we    = ex_mem.ctrl.mem_write;

    always_ff @(posedge clk) begin
        mem_wb <= '{ctrl: ex_mem.ctrl, pc: ex_mem.pc,
                    wdata: ex_mem.ctrl.mem_read ? m_data_rdata : ex_mem.alu};
        if (rst) begin
            mem_wb.ctrl <= '0;
        end
    end

    assign w_grf_we    = mem_wb.ctrl.reg_write;
    assign w_grf_addr  = mem_wb.ctrl.dst;
    assign w_grf_wdata = mem_wb.wdata;
    assign w_inst_addr = mem_wb.pc;

endmodule

`default_nettype wire

// ==== mips_alu.sv ====
`default_nettype none

`include "mips_defines.svh"

module mips_alu (
    input  mips_pkg::alu_op_e       op,
    input  logic [`MIPS_DATA_W-1:0] a,
    input  logic [`MIPS_DATA_W-1:0] b,
    output logic [`MIPS_DATA_W-1:0] y
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_OR: begin
                y = a | b;
            end
            // lui takes only the immediate
            default: begin
                y = {b[15:0], 16'h0000};
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== mips_assertions.sv ====
`default_nettype none

`include "mips_defines.svh"

module mips_assertions (
    input wire logic                    clk,
    input wire logic                    rst,
    input wire logic                    stall,
    input wire logic [31:0]             i_inst_addr,
    input wire logic                    m_data_we,
    input wire logic                    w_grf_we,
    input wire logic [`MIPS_REG_AW-1:0] w_grf_addr
);

    // number of assertion failures so far
    int fails = 0;

    // no store may leave the pipeline right after reset
    reset_quiet: assert property (@(posedge clk) rst |=> !m_data_we)
        else begin
            $error("store pulse in the cycle after reset");
            fails++;
        end

    zero_reg_write: assert property (@(posedge clk) w_grf_we |-> w_grf_addr != '0)
        else begin
            $error("writeback reported for register 0");
            fails++;
        end

    // fetch address is frozen while the hazard unit stalls
    stall_holds_pc: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(i_inst_addr))
        else begin
            $error("fetch address moved during a stall");
            fails++;
        end

endmodule

bind mips mips_assertions u_assertions (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .i_inst_addr(i_inst_addr),
    .m_data_we(m_data_we),
    .w_grf_we(w_grf_we),
    .w_grf_addr(w_grf_addr)
);

`default_nettype wire

// ==== mips_checker.sv ====
`default_nettype none

`include "mips_defines.svh"

module mips_checker #(
    parameter int IMEM_AW = 9
) (
    input wire logic                    clk,
    input wire logic                    build,
    input wire logic [31:0]             imem [0:(1<<IMEM_AW)-1],
    input wire logic [`MIPS_DATA_W-1:0] dmem_init [0:15],
    input wire logic                    w_grf_we,
    input wire logic [`MIPS_REG_AW-1:0] w_grf_addr,
    input wire logic [`MIPS_DATA_W-1:0] w_grf_wdata,
    input wire logic [31:0]             w_inst_addr,
    input wire logic                    m_data_we,
    input wire logic [31:0]             m_data_addr,
    input wire logic [`MIPS_DATA_W-1:0] m_data_wdata,
    output int                          errors,
    output int                          pending,
    output int                          wb_seen,
    output int                          wb_expected
);
    import mips_pkg::*;

    typedef struct packed {
        logic [31:0]             pc;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_DATA_W-1:0] data;
    } wb_exp_t;

    typedef struct packed {
        logic [31:0]             addr;
        logic [`MIPS_DATA_W-1:0] data;
    } st_exp_t;

    wb_exp_t                 wb_q [$];
    st_exp_t                 st_q [$];
    logic [`MIPS_DATA_W-1:0] m_regs [0:`MIPS_REG_COUNT-1];
    logic [`MIPS_DATA_W-1:0] m_mem [0:15];
    logic [31:0]             m_pc;
    logic [31:0]             m_npc;
    int                      err_count = 0;
    int                      wb_count = 0;
    int                      wb_total = 0;
    int                      q_left = 0;

    assign errors      = err_count;
    assign wb_seen     = wb_count;
    assign wb_expected = wb_total;
    assign pending     = q_left;

    function automatic void put_wb(input logic [`MIPS_REG_AW-1:0] r,
                                   input logic [`MIPS_DATA_W-1:0] v);
        if (r != '0) begin
            m_regs[r] = v;
            wb_q.push_back('{pc: m_pc, addr: r, data: v});
        end
    endfunction

    // one instruction of the reference model, returns 1 at the closing self-loop
    function automatic logic exec_one(input logic [31:0] instr);
        opcode_e     op;
        funct_e      fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] ea;
        logic [31:0] target;
        logic [31:0] npc_new;
        logic        done;
        op      = opcode_e'(instr[31:26]);
        fn      = funct_e'(instr[5:0]);
        a       = m_regs[instr[25:21]];
        b       = m_regs[instr[20:16]];
        sext    = {{16{instr[15]}}, instr[15:0]};
        ea      = a + sext;
        target  = m_npc + {sext[29:0], 2'b00};
        npc_new = m_npc + 32'd4;
        done    = 1'b0;
        case (op)
            OP_SPECIAL: begin
                if (fn == FN_ADDU) begin
                    put_wb(instr[15:11], a + b);
                end else if (fn == FN_SUBU) begin
                    put_wb(instr[15:11], a - b);
                end
            end
            OP_ORI: put_wb(instr[20:16], a | {16'h0000, instr[15:0]});
            OP_LUI: put_wb(instr[20:16], {instr[15:0], 16'h0000});
            OP_LW:  put_wb(instr[20:16], m_mem[ea[5:2]]);
            OP_SW: begin
                m_mem[ea[5:2]] = b;
                st_q.push_back('{addr: ea, data: b});
            end
            OP_BEQ: begin
                if (a == b) begin
                    npc_new = target;
                    done    = (target == m_pc);
                end
            end
            default: begin
            end
        endcase
        // delay slot: the next pc was fixed one instruction earlier
        m_pc  = m_npc;
        m_npc = npc_new;
        return done;
    endfunction

    function automatic void build_model();
        logic [31:0] idx;
        logic [31:0] instr;
        for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            m_mem[i] = dmem_init[i];
        end
        wb_q.delete();
        st_q.delete();
        m_pc  = `MIPS_TEXT_BASE;
        m_npc = `MIPS_TEXT_BASE + 32'd4;
        for (int step = 0; step < 4 * (1 << IMEM_AW); step++) begin
            idx   = (m_pc - `MIPS_TEXT_BASE) >> 2;
            instr = (idx < (1 << IMEM_AW)) ? imem[idx[IMEM_AW-1:0]] : 32'h0;
            if (exec_one(instr)) begin
                break;
            end
        end
        wb_total = wb_q.size();
    endfunction

    task automatic mismatch(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        $display("MISMATCH %s got %h expected %h", name, got, exp);
        err_count++;
    endtask

    always @(posedge clk) begin
        wb_exp_t e;
        st_exp_t s;
        if (build) begin
            build_model();
            wb_count = 0;
        end else begin
            if (w_grf_we) begin
                wb_count++;
                if (wb_q.size() == 0) begin
                    $display("register write to $%0d from pc %h was not expected",
                             w_grf_addr, w_inst_addr);
                    err_count++;
                end else begin
                    e = wb_q.pop_front();
                    if (w_inst_addr !== e.pc) mismatch("w_inst_addr", w_inst_addr, e.pc);
                    if (w_grf_addr !== e.addr) begin
                        mismatch("w_grf_addr", 32'(w_grf_addr), 32'(e.addr));
                    end
                    if (w_grf_wdata !== e.data) mismatch("w_grf_wdata", w_grf_wdata, e.data);
                end
            end
            if (m_data_we) begin
                if (st_q.size() == 0) begin
                    $display("store to %h was not expected", m_data_addr);
                    err_count++;
                end else begin
                    s = st_q.pop_front();
                    if (m_data_addr !== s.addr) mismatch("m_data_addr", m_data_addr, s.addr);
                    if (m_data_wdata !== s.data) begin
                        mismatch("m_data_wdata", m_data_wdata, s.data);
                    end
                end
            end
        end
        // registered so the sequencer sees a settled count at the edge
        q_left <= wb_q.size() + st_q.size();
    end

endmodule

`default_nettype wire

// ==== mips_decode.sv ====
`default_nettype none

`include "mips_defines.svh"

module mips_decode (
    input  logic [31:0]             instr,
    input  logic [31:0]             pc,
    input  logic [`MIPS_DATA_W-1:0] rs_val,
    input  logic [`MIPS_DATA_W-1:0] rt_val,
    output mips_pkg::ctrl_t         ctrl,
    output logic [`MIPS_REG_AW-1:0] rs_addr,
    output logic [`MIPS_REG_AW-1:0] rt_addr,
    output logic [`MIPS_DATA_W-1:0] imm,
    output logic                    rs_use,
    output logic                    rt_use,
    output logic                    branch_taken,
    output logic [31:0]             branch_target
);
    import mips_pkg::*;

    opcode_e                 op;
    funct_e                  fn;
    logic [`MIPS_REG_AW-1:0] f_rs;
    logic [`MIPS_REG_AW-1:0] f_rt;
    logic [`MIPS_REG_AW-1:0] f_rd;
    logic [`MIPS_DATA_W-1:0] imm_sext;
    logic [`MIPS_DATA_W-1:0] imm_zext;

    assign op       = opcode_e'(instr[31:26]);
    assign fn       = funct_e'(instr[5:0]);
    assign f_rs     = instr[25:21];
    assign f_rt     = instr[20:16];
    assign f_rd     = instr[15:11];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};

    // unused operands keep address 0 so they never hit a producer
    always_comb begin
        ctrl    = '0;
        rs_addr = '0;
        rt_addr = '0;
        imm     = imm_zext;
        rs_use  = 1'b1;
        rt_use  = 1'b1;
        case (op)
            OP_SPECIAL: begin
                if (fn == FN_ADDU || fn == FN_SUBU) begin
                    ctrl.alu_op    = (fn == FN_SUBU) ? ALU_SUB : ALU_ADD;
                    ctrl.reg_write = 1'b1;
                    ctrl.dst       = f_rd;
                    ctrl.t_new     = 2'd1;
                    rs_addr        = f_rs;
                    rt_addr        = f_rt;
                end
            end
            OP_ORI, OP_LUI: begin
                ctrl.alu_op    = (op == OP_LUI) ? ALU_LUI : ALU_OR;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dst       = f_rt;
                ctrl.t_new     = 2'd1;
                rs_addr        = (op == OP_LUI) ? '0 : f_rs;
            end
            OP_LW: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dst       = f_rt;
                ctrl.t_new     = 2'd2;
                rs_addr        = f_rs;
                imm            = imm_sext;
            end
            OP_SW: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                rs_addr        = f_rs;
                rt_addr        = f_rt;
                imm            = imm_sext;
            end
            OP_BEQ: begin
                ctrl.is_branch = 1'b1;
                rs_addr        = f_rs;
                rt_addr        = f_rt;
                rs_use         = 1'b0;
                rt_use         = 1'b0;
                imm            = imm_sext;
            end
            default: begin
                ctrl = '0;
            end
        endcase
        // writes to $0 are dropped here
        if (ctrl.dst == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    assign branch_taken  = ctrl.is_branch && (rs_val == rt_val);
    assign branch_target = pc + 32'd4 + {imm_sext[29:0], 2'b00};

endmodule

`default_nettype wire

// ==== mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath width
`define MIPS_DATA_W 32

// register file addressing
`define MIPS_REG_AW 5
`define MIPS_REG_COUNT 32

// reset value of the program counter
`define MIPS_TEXT_BASE 32'h0000_3000

`endif

// ==== mips_fetch.sv ====
`default_nettype none

`include "mips_defines.svh"

module mips_fetch (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        branch_taken,
    input  logic [31:0] branch_target,
    output logic [31:0] pc
);

    logic [31:0] pc_next;

    // redirect only once the branch leaves decode
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `MIPS_TEXT_BASE;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== mips_grf.sv ====
`default_nettype none

`include "mips_defines.svh"

module mips_grf (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    we,
    input  logic [`MIPS_REG_AW-1:0] waddr,
    input  logic [`MIPS_DATA_W-1:0] wdata,
    input  logic [`MIPS_REG_AW-1:0] raddr1,
    input  logic [`MIPS_REG_AW-1:0] raddr2,
    output logic [`MIPS_DATA_W-1:0] rdata1,
    output logic [`MIPS_DATA_W-1:0] rdata2
);

    // $0 has no storage
    logic [`MIPS_DATA_W-1:0] regs [1:`MIPS_REG_COUNT-1];
    logic                    wr_live;

    assign wr_live = we && (waddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so decode sees this cycle's writeback
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (wr_live && raddr1 == waddr) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (wr_live && raddr2 == waddr) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// ==== mips_hazard.sv ====
`default_nettype none

`include "mips_defines.svh"

module mips_hazard (
    input  logic [`MIPS_REG_AW-1:0] dec_rs,
    input  logic [`MIPS_REG_AW-1:0] dec_rt,
    input  logic                    rs_use,
    input  logic                    rt_use,
    input  mips_pkg::id_ex_t        id_ex,
    input  mips_pkg::ctrl_t         ex_mem,
    input  mips_pkg::ctrl_t         mem_wb,
    output logic                    stall,
    output mips_pkg::fwd_sel_e      fwd_dec_rs,
    output mips_pkg::fwd_sel_e      fwd_dec_rt,
    output mips_pkg::fwd_sel_e      fwd_ex_rs,
    output mips_pkg::fwd_sel_e      fwd_ex_rt
);
    import mips_pkg::*;

    function automatic logic hit(input ctrl_t c, input logic [`MIPS_REG_AW-1:0] addr);
        return c.reg_write && (c.dst == addr) && (addr != '0);
    endfunction

    // producer in EX needs t_new more cycles, in MEM one fewer
    function automatic logic late(input logic [`MIPS_REG_AW-1:0] addr, input logic use_t);
        logic [1:0] need;
        need = {1'b0, use_t};
        return (hit(id_ex.ctrl, addr) && id_ex.ctrl.t_new > need) ||
               (hit(ex_mem, addr) && ex_mem.t_new > need + 2'd1);
    endfunction

    // youngest matching producer wins; a younger one not ready blocks older ones
    function automatic fwd_sel_e pick(input logic [`MIPS_REG_AW-1:0] addr, input logic blocked);
        if (blocked) begin
            return FWD_REG;
        end
        if (hit(ex_mem, addr)) begin
            if (ex_mem.t_new == 2'd1) begin
                return FWD_EX_MEM;
            end
            return FWD_REG;
        end
        if (hit(mem_wb, addr)) begin
            return FWD_MEM_WB;
        end
        return FWD_REG;
    endfunction

    assign stall = late(dec_rs, rs_use) || late(dec_rt, rt_use);

    assign fwd_dec_rs = pick(dec_rs, hit(id_ex.ctrl, dec_rs));
    assign fwd_dec_rt = pick(dec_rt, hit(id_ex.ctrl, dec_rt));
    assign fwd_ex_rs  = pick(id_ex.rs_addr, 1'b0);
    assign fwd_ex_rt  = pick(id_ex.rt_addr, 1'b0);

endmodule

`default_nettype wire

// ==== mips_pkg.sv ====
`default_nettype none

`include "mips_defines.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23
    } funct_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_OR,
        ALU_LUI
    } alu_op_e;

    // where an operand value is taken from
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e                 alu_op;
        logic                    use_imm;
        logic                    mem_read;
        logic                    mem_write;
        logic                    reg_write;
        logic [`MIPS_REG_AW-1:0] dst;
        // cycles from EX until the result exists
        logic [1:0]              t_new;
        logic                    is_branch;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [31:0]             pc;
        logic [`MIPS_REG_AW-1:0] rs_addr;
        logic [`MIPS_REG_AW-1:0] rt_addr;
        logic [`MIPS_DATA_W-1:0] rs_val;
        logic [`MIPS_DATA_W-1:0] rt_val;
        logic [`MIPS_DATA_W-1:0] imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [31:0]             pc;
        logic [`MIPS_DATA_W-1:0] alu;
        logic [`MIPS_DATA_W-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [31:0]             pc;
        logic [`MIPS_DATA_W-1:0] wdata;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== tb_mips.sv ====
`default_nettype none

`include "mips_defines.svh"

module tb_mips;
    import mips_pkg::*;

    localparam int          IMEM_AW = 9;
    localparam int          IMEM_WORDS = 1 << IMEM_AW;
    localparam logic [31:0] NOP = 32'h0000_0000;

    logic                    clk;
    logic                    rst;
    logic                    build;
    logic [31:0]             i_inst_addr;
    logic [31:0]             i_inst_rdata;
    logic [31:0]             i_word;
    logic [`MIPS_DATA_W-1:0] m_data_rdata;
    logic [31:0]             m_data_addr;
    logic [`MIPS_DATA_W-1:0] m_data_wdata;
    logic                    m_data_we;
    logic                    w_grf_we;
    logic [`MIPS_REG_AW-1:0] w_grf_addr;
    logic [`MIPS_DATA_W-1:0] w_grf_wdata;
    logic [31:0]             w_inst_addr;
    logic [31:0]             imem [0:IMEM_WORDS-1];
    logic [`MIPS_DATA_W-1:0] dmem [0:15];
    logic [31:0]             lfsr;
    logic [IMEM_AW-1:0]      prog_len;
    int                      errors;
    int                      pending;
    int                      wb_seen;
    int                      wb_expected;
    int                      n_tests;
    int                      n_failed;
    int                      reset_errs;

    mips i_mips (
        .clk(clk),
        .rst(rst),
        .i_inst_addr(i_inst_addr),
        .i_inst_rdata(i_inst_rdata),
        .m_data_rdata(m_data_rdata),
        .m_data_addr(m_data_addr),
        .m_data_wdata(m_data_wdata),
        .m_data_we(m_data_we),
        .w_grf_we(w_grf_we),
        .w_grf_addr(w_grf_addr),
        .w_grf_wdata(w_grf_wdata),
        .w_inst_addr(w_inst_addr)
    );

    mips_checker #(.IMEM_AW(IMEM_AW)) i_checker (
        .clk(clk),
        .build(build),
        .imem(imem),
        .dmem_init(dmem),
        .w_grf_we(w_grf_we),
        .w_grf_addr(w_grf_addr),
        .w_grf_wdata(w_grf_wdata),
        .w_inst_addr(w_inst_addr),
        .m_data_we(m_data_we),
        .m_data_addr(m_data_addr),
        .m_data_wdata(m_data_wdata),
        .errors(errors),
        .pending(pending),
        .wb_seen(wb_seen),
        .wb_expected(wb_expected)
    );

    // memory models, both read combinationally
    assign i_word       = (i_inst_addr - `MIPS_TEXT_BASE) >> 2;
    assign i_inst_rdata = (i_word < IMEM_WORDS) ? imem[i_word[IMEM_AW-1:0]] : NOP;
    assign m_data_rdata = dmem[m_data_addr[5:2]];

    always @(posedge clk) begin
        if (m_data_we) begin
            dmem[m_data_addr[5:2]] <= m_data_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input funct_e fn, input int rd, input int rs,
                                          input int rt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input int rt, input int rs,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic put(input logic [31:0] w);
        imem[prog_len] <= w;
        prog_len = prog_len + 1'b1;
    endtask

    // reset goes up together with the new program and memory contents
    task automatic start_test();
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] <= NOP;
        end
        for (int i = 0; i < 16; i++) begin
            dmem[i] <= {8'hd5, 4'h0, 4'(i), 8'h3c, ~4'(i), 4'(i)};
        end
        prog_len = '0;
    endtask

    task automatic finish_test(input string name);
        int errs_before;
        int resets_before;
        int cycles;
        put(enc_i(OP_BEQ, 0, 0, 16'hffff));
        put(NOP);
        errs_before   = errors;
        resets_before = reset_errs;
        build <= 1'b1;
        @(posedge clk);
        build <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        if (i_inst_addr !== `MIPS_TEXT_BASE) begin
            $display("MISMATCH i_inst_addr got %h expected %h", i_inst_addr, `MIPS_TEXT_BASE);
            reset_errs++;
        end
        if (w_grf_we !== 1'b0 || m_data_we !== 1'b0) begin
            $display("MISMATCH w_grf_we/m_data_we got %h/%h expected 0/0", w_grf_we, m_data_we);
            reset_errs++;
        end
        rst <= 1'b0;
        cycles = 0;
        while (pending != 0 && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        n_tests++;
        if (pending != 0) begin
            $display("test %s: timeout, still waiting for %0d writebacks or stores",
                     name, pending);
            n_failed++;
        end else begin
            // extra writes would show up in this window
            for (int i = 0; i < 20; i++) begin
                @(posedge clk);
            end
            if (errors == errs_before && reset_errs == resets_before &&
                wb_seen == wb_expected) begin
                $display("test %s: ok, %0d writebacks", name, wb_seen);
            end else begin
                $display("test %s: FAILED, %0d writebacks of %0d", name, wb_seen, wb_expected);
                n_failed++;
            end
        end
    endtask

    task automatic gen_random(input int n);
        logic prev_branch;
        int   kind;
        int   off;
        prev_branch = 1'b0;
        for (int k = 0; k < n; k++) begin
            kind = int'(rand_bits(3));
            // no branch in a delay slot, none right before the closing loop
            if (kind == 6 && (prev_branch || k >= n - 1)) kind = 0;
            case (kind)
                0: put(enc_r(FN_ADDU, rand_bits(3), rand_bits(3), rand_bits(3)));
                1: put(enc_r(FN_SUBU, rand_bits(3), rand_bits(3), rand_bits(3)));
                3: put(enc_i(OP_LUI, rand_bits(3), 0, 16'(rand_bits(16))));
                4: put(enc_i(OP_LW, rand_bits(3), 0, 16'(rand_bits(4) << 2)));
                5: put(enc_i(OP_SW, rand_bits(3), 0, 16'(rand_bits(4) << 2)));
                6: begin
                    off = 1 + int'(rand_bits(2));
                    if (k + 1 + off > n) off = n - 1 - k;
                    put(enc_i(OP_BEQ, rand_bits(3), rand_bits(3), 16'(off)));
                end
                default: put(enc_i(OP_ORI, rand_bits(3), rand_bits(3), 16'(rand_bits(16))));
            endcase
            prev_branch = (kind == 6);
        end
    endtask

    initial begin
        rst         = 1'b1;
        build       = 1'b0;
        lfsr        = 32'ha2e2;
        n_tests     = 0;
        n_failed    = 0;
        reset_errs  = 0;

        start_test();
        finish_test("reset");

        start_test();
        put(enc_i(OP_LUI, 1, 0, 16'h1234));
        put(enc_i(OP_ORI, 1, 1, 16'h5678));
        put(enc_r(FN_ADDU, 2, 1, 1));
        put(enc_r(FN_SUBU, 3, 2, 1));
        put(enc_i(OP_ORI, 4, 3, 16'h00ff));
        put(enc_r(FN_ADDU, 5, 4, 2));
        put(enc_i(OP_LUI, 6, 0, 16'h8001));
        put(enc_r(FN_SUBU, 7, 5, 6));
        finish_test("alu_chain");

        start_test();
        put(enc_i(OP_LW, 1, 0, 16'd8));
        put(enc_r(FN_ADDU, 2, 1, 1));
        put(enc_i(OP_LW, 3, 0, 16'd12));
        put(enc_r(FN_SUBU, 4, 3, 1));
        put(enc_r(FN_ADDU, 5, 4, 3));
        finish_test("load_use");

        start_test();
        put(enc_i(OP_ORI, 1, 0, 16'h0abc));
        put(enc_i(OP_SW, 1, 0, 16'd4));
        put(enc_r(FN_ADDU, 2, 1, 1));
        put(enc_i(OP_SW, 2, 0, 16'd8));
        put(enc_i(OP_LW, 3, 0, 16'd8));
        put(enc_i(OP_SW, 3, 0, 16'd12));
        finish_test("store");

        start_test();
        put(enc_i(OP_ORI, 1, 0, 16'd5));
        put(enc_i(OP_ORI, 2, 0, 16'd5));
        put(enc_i(OP_BEQ, 2, 1, 16'd2));
        put(enc_i(OP_ORI, 3, 0, 16'd1));
        put(enc_i(OP_ORI, 4, 0, 16'd2));
        put(enc_i(OP_ORI, 5, 0, 16'd3));
        put(enc_i(OP_BEQ, 1, 5, 16'd1));
        put(enc_r(FN_ADDU, 6, 1, 2));
        put(enc_i(OP_LW, 3, 0, 16'd0));
        put(enc_i(OP_BEQ, 3, 3, 16'd1));
        put(enc_i(OP_ORI, 4, 0, 16'd9));
        put(enc_i(OP_LW, 7, 0, 16'd4));
        put(enc_i(OP_ORI, 6, 0, 16'd7));
        put(enc_i(OP_BEQ, 0, 7, 16'd1));
        put(enc_r(FN_ADDU, 2, 7, 7));
        put(enc_i(OP_SW, 2, 0, 16'd8));
        finish_test("branches");

        start_test();
        gen_random(300);
        finish_test("random");

        $display("%0d tests, %0d failed, errors: %0d check, %0d reset, %0d assertion",
                 n_tests, n_failed, errors, reset_errs, i_mips.u_assertions.fails);
        if (n_failed == 0 && errors == 0 && reset_errs == 0 &&
            i_mips.u_assertions.fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
